// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_scheduler
FILELIST  ?= pifo_sched.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/pifo_sched_config.svh ====
`ifndef PIFO_SCHED_CONFIG_SVH
`define PIFO_SCHED_CONFIG_SVH

// stream width in bits
`define PS_DATA_WIDTH 64

// output ports, one queue each
`define PS_NUM_QUEUES 4

// packet slots per queue, also calendar depth
`define PS_NUM_SLOTS 8

// longest packet in words
`define PS_SLOT_WORDS 8

// pifo rank
`define PS_RANK_WIDTH 15

// opaque flow tag carried in tuser
`define PS_FLOW_WIDTH 12

`endif

// ==== common/pifo_sched_pkg.sv ====
`include "pifo_sched_config.svh"

package pifo_sched_pkg;

    typedef logic [`PS_DATA_WIDTH-1:0] data_t;
    typedef logic [`PS_DATA_WIDTH/8-1:0] keep_t;
    typedef logic [`PS_NUM_QUEUES-1:0] port_mask_t;
    typedef logic [`PS_RANK_WIDTH-1:0] rank_t;

    // switch metadata, lower half of tuser
    typedef struct packed {
        logic [`PS_FLOW_WIDTH-1:0] flow;
        port_mask_t                dst_ports;
    } meta_t;

    typedef struct packed {
        logic  valid;
        rank_t rank;
    } pifo_info_t;

    typedef struct packed {
        pifo_info_t pifo;
        meta_t      meta;
    } tuser_in_t;

    typedef logic [$clog2(`PS_NUM_SLOTS)-1:0] slot_t;
    // 1 to max words, so one extra bit
    typedef logic [$clog2(`PS_SLOT_WORDS):0] len_t;

    typedef struct packed {
        rank_t rank;
        slot_t slot;
        len_t  len;
        meta_t meta;
    } cal_entry_t;

endpackage

// ==== design/enqueue_agent.sv ====
`timescale 1ns/1ns

module enqueue_agent
(
    input  logic                       axis_aclk,
    input  logic                       axis_resetn,

    input  pifo_sched_pkg::data_t      s_axis_tdata,
    input  pifo_sched_pkg::keep_t      s_axis_tkeep,
    input  pifo_sched_pkg::tuser_in_t  s_axis_tuser,
    input  logic                       s_axis_tvalid,
    input  logic                       s_axis_tlast,

    input  pifo_sched_pkg::port_mask_t queue_full,

    output pifo_sched_pkg::data_t      wr_data,
    output pifo_sched_pkg::keep_t      wr_keep,
    output logic                       wr_last,
    output pifo_sched_pkg::meta_t      wr_meta,
    output pifo_sched_pkg::rank_t      wr_rank,
    output pifo_sched_pkg::port_mask_t wr_en,
    output pifo_sched_pkg::port_mask_t insert_en
);

    pifo_sched_pkg::data_t      data_q;
    pifo_sched_pkg::keep_t      keep_q;
    pifo_sched_pkg::tuser_in_t  tuser_q;
    logic                       valid_q;
    logic                       last_q;

    logic                       sop;
    pifo_sched_pkg::port_mask_t sel_q;
    pifo_sched_pkg::port_mask_t first_mask;
    pifo_sched_pkg::port_mask_t pkt_mask;

    ////////////////////////////////////////////////////////////////////////////
    // input register stage
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end
        else
        begin
            valid_q <= s_axis_tvalid;
            last_q  <= s_axis_tlast;
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        data_q  <= s_axis_tdata;
        keep_q  <= s_axis_tkeep;
        tuser_q <= s_axis_tuser;
    end

    ////////////////////////////////////////////////////////////////////////////
    // queue selection
    ////////////////////////////////////////////////////////////////////////////
    // full queues drop the packet; no pifo info, no queue
    assign first_mask = tuser_q.pifo.valid ?
                        (tuser_q.meta.dst_ports & ~queue_full) : '0;

    assign pkt_mask = sop ? first_mask : sel_q;

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            sop   <= 1'b1;
            sel_q <= '0;
        end
        else if (valid_q)
        begin
            sop <= last_q;
            if (sop)
                sel_q <= first_mask;
        end
    end

    // broadcast to every queue
    assign wr_data = data_q;
    assign wr_keep = keep_q;
    assign wr_last = last_q;
    assign wr_meta = tuser_q.meta;
    assign wr_rank = tuser_q.pifo.rank;

    assign wr_en     = valid_q ? pkt_mask : '0;
    assign insert_en = (valid_q && last_q) ? pkt_mask : '0;

endmodule

// ==== design/scheduler_top.sv ====
`timescale 1ns/1ns
`include "pifo_sched_config.svh"

module scheduler_top
(
    input  logic                            axis_aclk,
    input  logic                            axis_resetn,

    input  pifo_sched_pkg::data_t           s_axis_tdata,
    input  pifo_sched_pkg::keep_t           s_axis_tkeep,
    input  pifo_sched_pkg::tuser_in_t       s_axis_tuser,
    input  logic                            s_axis_tvalid,
    input  logic                            s_axis_tlast,
    output logic                            s_axis_tready,

    input  pifo_sched_pkg::port_mask_t      m_axis_tready,
    output wire pifo_sched_pkg::data_t      m_axis_tdata [`PS_NUM_QUEUES],
    output wire pifo_sched_pkg::keep_t      m_axis_tkeep [`PS_NUM_QUEUES],
    output wire pifo_sched_pkg::meta_t      m_axis_tuser [`PS_NUM_QUEUES],
    output wire pifo_sched_pkg::rank_t      m_axis_tpifo [`PS_NUM_QUEUES],
    output wire pifo_sched_pkg::port_mask_t m_axis_tvalid,
    output wire pifo_sched_pkg::port_mask_t m_axis_tlast
);

    pifo_sched_pkg::data_t      wr_data;
    pifo_sched_pkg::keep_t      wr_keep;
    logic                       wr_last;
    pifo_sched_pkg::meta_t      wr_meta;
    pifo_sched_pkg::rank_t      wr_rank;
    pifo_sched_pkg::port_mask_t wr_en;
    pifo_sched_pkg::port_mask_t insert_en;
    wire pifo_sched_pkg::port_mask_t queue_full;

    // drop policy, never back-pressure once out of reset
    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
            s_axis_tready <= 1'b0;
        else
            s_axis_tready <= 1'b1;
    end

    enqueue_agent u_enqueue_agent
    (
        .axis_aclk     (axis_aclk),
        .axis_resetn   (axis_resetn),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tkeep  (s_axis_tkeep),
        .s_axis_tuser  (s_axis_tuser),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tlast  (s_axis_tlast),
        .queue_full    (queue_full),
        .wr_data       (wr_data),
        .wr_keep       (wr_keep),
        .wr_last       (wr_last),
        .wr_meta       (wr_meta),
        .wr_rank       (wr_rank),
        .wr_en         (wr_en),
        .insert_en     (insert_en)
    );

    ////////////////////////////////////////////////////////////////////////////
    // one queue per output port
    ////////////////////////////////////////////////////////////////////////////
    for (genvar q = 0; q < `PS_NUM_QUEUES; q++)
    begin : g_queue
        output_queue u_output_queue
        (
            .axis_aclk     (axis_aclk),
            .axis_resetn   (axis_resetn),
            .wr_data       (wr_data),
            .wr_keep       (wr_keep),
            .wr_last       (wr_last),
            .wr_meta       (wr_meta),
            .wr_rank       (wr_rank),
            .wr_en         (wr_en[q]),
            .insert_en     (insert_en[q]),
            .m_axis_tready (m_axis_tready[q]),
            .queue_full    (queue_full[q]),
            .m_axis_tdata  (m_axis_tdata[q]),
            .m_axis_tkeep  (m_axis_tkeep[q]),
            .m_axis_tuser  (m_axis_tuser[q]),
            .m_axis_tpifo  (m_axis_tpifo[q]),
            .m_axis_tvalid (m_axis_tvalid[q]),
            .m_axis_tlast  (m_axis_tlast[q])
        );
    end

endmodule

// ==== output_queue/output_queue.sv ====
`timescale 1ns/1ns
`include "pifo_sched_config.svh"

module output_queue
(
    input  logic                        axis_aclk,
    input  logic                        axis_resetn,

    input  pifo_sched_pkg::data_t       wr_data,
    input  pifo_sched_pkg::keep_t       wr_keep,
    input  logic                        wr_last,
    input  pifo_sched_pkg::meta_t       wr_meta,
    input  pifo_sched_pkg::rank_t       wr_rank,
    input  logic                        wr_en,
    input  logic                        insert_en,
    input  logic                        m_axis_tready,

    output logic                        queue_full,
    output pifo_sched_pkg::data_t       m_axis_tdata,
    output pifo_sched_pkg::keep_t       m_axis_tkeep,
    output pifo_sched_pkg::meta_t       m_axis_tuser,
    output pifo_sched_pkg::rank_t       m_axis_tpifo,
    output logic                        m_axis_tvalid,
    output logic                        m_axis_tlast
);

    localparam int WIDX = $clog2(`PS_SLOT_WORDS);

    pifo_sched_pkg::data_t      mem_data [`PS_NUM_SLOTS][`PS_SLOT_WORDS];
    pifo_sched_pkg::keep_t      mem_keep [`PS_NUM_SLOTS][`PS_SLOT_WORDS];
    logic                       mem_last [`PS_NUM_SLOTS][`PS_SLOT_WORDS];

    logic [`PS_NUM_SLOTS-1:0]   slot_used;
    pifo_sched_pkg::slot_t      alloc_slot;

    logic                       wr_active;
    pifo_sched_pkg::slot_t      wr_slot;
    pifo_sched_pkg::len_t       wr_cnt;
    pifo_sched_pkg::slot_t      wr_cur_slot;
    logic [WIDX-1:0]            wr_word;
    pifo_sched_pkg::cal_entry_t ins_entry;

    pifo_sched_pkg::cal_entry_t head_entry;
    logic                       cal_empty;
    logic                       pop;

    logic                       busy;
    pifo_sched_pkg::cal_entry_t rd_entry;
    pifo_sched_pkg::len_t       rd_cnt;
    logic                       load;
    logic                       done;

    ////////////////////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////////////////////
    // lowest free slot
    always_comb
    begin
        alloc_slot = '0;
        for (int i = `PS_NUM_SLOTS - 1; i >= 0; i--)
            if (!slot_used[i])
                alloc_slot = pifo_sched_pkg::slot_t'(i);
    end

    // counts the slot held by a packet still being written
    assign queue_full = &slot_used;

    assign wr_cur_slot = wr_active ? wr_slot : alloc_slot;
    assign wr_word     = wr_active ? wr_cnt[WIDX-1:0] : '0;

    assign ins_entry.rank = wr_rank;
    assign ins_entry.slot = wr_cur_slot;
    assign ins_entry.len  = wr_active ? wr_cnt + pifo_sched_pkg::len_t'(1)
                                      : pifo_sched_pkg::len_t'(1);
    assign ins_entry.meta = wr_meta;

    always_ff @(posedge axis_aclk)
    begin
        if (wr_en)
        begin
            mem_data[wr_cur_slot][wr_word] <= wr_data;
            mem_keep[wr_cur_slot][wr_word] <= wr_keep;
            mem_last[wr_cur_slot][wr_word] <= wr_last;
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            wr_active <= 1'b0;
            wr_slot   <= '0;
            wr_cnt    <= '0;
            slot_used <= '0;
        end
        else
        begin
            if (done)
                slot_used[rd_entry.slot] <= 1'b0;
            if (wr_en)
            begin
                if (!wr_active)
                begin
                    slot_used[alloc_slot] <= 1'b1;
                    wr_slot               <= alloc_slot;
                end
                wr_active <= !wr_last;
                wr_cnt    <= wr_last ? '0 : ins_entry.len;
            end
        end
    end

    pifo_calendar u_pifo_calendar
    (
        .axis_aclk    (axis_aclk),
        .axis_resetn  (axis_resetn),
        .insert       (insert_en),
        .insert_entry (ins_entry),
        .pop          (pop),
        .head_entry   (head_entry),
        .empty        (cal_empty)
    );

    ////////////////////////////////////////////////////////////////////////////
    // dequeue side
    ////////////////////////////////////////////////////////////////////////////
    assign pop  = !busy && !cal_empty;
    assign load = busy && (rd_cnt != rd_entry.len) && (!m_axis_tvalid || m_axis_tready);
    assign done = m_axis_tvalid && m_axis_tready && m_axis_tlast;

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            busy          <= 1'b0;
            rd_cnt        <= '0;
            m_axis_tvalid <= 1'b0;
        end
        else
        begin
            if (pop)
            begin
                busy   <= 1'b1;
                rd_cnt <= '0;
            end
            else if (done)
                busy <= 1'b0;
            else if (load)
                rd_cnt <= rd_cnt + pifo_sched_pkg::len_t'(1);

            if (load)
                m_axis_tvalid <= 1'b1;
            else if (m_axis_tready)
                m_axis_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (pop)
            rd_entry <= head_entry;
        if (load)
        begin
            m_axis_tdata <= mem_data[rd_entry.slot][rd_cnt[WIDX-1:0]];
            m_axis_tkeep <= mem_keep[rd_entry.slot][rd_cnt[WIDX-1:0]];
            m_axis_tlast <= mem_last[rd_entry.slot][rd_cnt[WIDX-1:0]];
        end
    end

    // entry stays put until the packet has left
    assign m_axis_tuser = rd_entry.meta;
    assign m_axis_tpifo = rd_entry.rank;

endmodule

// ==== output_queue/pifo_calendar.sv ====
`timescale 1ns/1ns
`include "pifo_sched_config.svh"

module pifo_calendar
(
    input  logic                        axis_aclk,
    input  logic                        axis_resetn,
    input  logic                        insert,
    input  pifo_sched_pkg::cal_entry_t  insert_entry,
    input  logic                        pop,
    output pifo_sched_pkg::cal_entry_t  head_entry,
    output logic                        empty
);

    localparam int DEPTH = `PS_NUM_SLOTS;
    localparam int CW    = $clog2(DEPTH) + 1;

    pifo_sched_pkg::cal_entry_t entries [DEPTH];
    pifo_sched_pkg::cal_entry_t up [DEPTH];
    pifo_sched_pkg::cal_entry_t dn [DEPTH];
    logic [CW-1:0]              count;
    logic [CW-1:0]              ins_pos;
    logic [CW-1:0]              pos_pop;
    logic                       do_pop;

    assign empty      = (count == '0);
    assign head_entry = entries[0];
    assign do_pop     = pop && !empty;

    // first entry ranked above the new one, ties stay ahead
    always_comb
    begin
        ins_pos = count;
        for (int i = DEPTH - 1; i >= 0; i--)
            if (i < count && entries[i].rank > insert_entry.rank)
                ins_pos = CW'(i);
    end

    // head leaves in the same cycle
    assign pos_pop = (ins_pos == '0) ? '0 : ins_pos - 1'b1;

    // neighbours for shifting toward and away from the head
    always_comb
    begin
        for (int i = 0; i < DEPTH - 1; i++)
            up[i] = entries[i + 1];
        up[DEPTH - 1] = entries[DEPTH - 1];
        dn[0] = entries[0];
        for (int i = 1; i < DEPTH; i++)
            dn[i] = entries[i - 1];
    end

    always_ff @(posedge axis_aclk)
    begin
        for (int i = 0; i < DEPTH; i++)
        begin
            if (insert && do_pop)
                entries[i] <= (i < pos_pop)  ? up[i] :
                              (i == pos_pop) ? insert_entry : entries[i];
            else if (insert)
                entries[i] <= (i < ins_pos)  ? entries[i] :
                              (i == ins_pos) ? insert_entry : dn[i];
            else if (do_pop)
                entries[i] <= up[i];
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
            count <= '0;
        else if (insert && !do_pop)
            count <= count + 1'b1;
        else if (do_pop && !insert)
            count <= count - 1'b1;
    end

endmodule

// ==== pifo_sched.f ====
+incdir+common
common/pifo_sched_pkg.sv
design/enqueue_agent.sv
output_queue/pifo_calendar.sv
output_queue/output_queue.sv
design/scheduler_top.sv
verif/tb_clock_gen.sv
verif/tb_scheduler.sv

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen
#(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 3
)
(
    output logic axis_aclk,
    output logic axis_resetn
);

    initial
    begin
        axis_aclk = 1'b0;
        forever #(HALF_PERIOD) axis_aclk = ~axis_aclk;
    end

    // release on a rising edge, after RESET_CYCLES of them
    initial
    begin
        axis_resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge axis_aclk);
        axis_resetn <= 1'b1;
    end

endmodule

// ==== verif/tb_scheduler.sv ====
`timescale 1ns/1ns
`include "pifo_sched_config.svh"

module tb_scheduler;

    localparam int NQ         = `PS_NUM_QUEUES;
    localparam int N_RAND     = 300;
    localparam int TOTAL_PKTS = 1 + 8 + 9 + 1 + N_RAND;
    localparam int TIMEOUT_NS = TOTAL_PKTS * 200 * 10;

    logic                              axis_aclk;
    logic                              axis_resetn;
    pifo_sched_pkg::data_t             s_axis_tdata;
    pifo_sched_pkg::keep_t             s_axis_tkeep;
    pifo_sched_pkg::tuser_in_t         s_axis_tuser;
    logic                              s_axis_tvalid;
    logic                              s_axis_tlast;
    logic                              s_axis_tready;
    pifo_sched_pkg::port_mask_t        m_axis_tready;
    wire pifo_sched_pkg::data_t        m_axis_tdata [NQ];
    wire pifo_sched_pkg::keep_t        m_axis_tkeep [NQ];
    wire pifo_sched_pkg::meta_t        m_axis_tuser [NQ];
    wire pifo_sched_pkg::rank_t        m_axis_tpifo [NQ];
    wire pifo_sched_pkg::port_mask_t   m_axis_tvalid;
    wire pifo_sched_pkg::port_mask_t   m_axis_tlast;

    // model storage for every packet sent
    pifo_sched_pkg::data_t pkt_data [TOTAL_PKTS][`PS_SLOT_WORDS];
    pifo_sched_pkg::keep_t pkt_keep [TOTAL_PKTS][`PS_SLOT_WORDS];
    pifo_sched_pkg::meta_t pkt_meta [TOTAL_PKTS];
    pifo_sched_pkg::rank_t pkt_rank [TOTAL_PKTS];
    int                    pkt_len  [TOTAL_PKTS];
    int                    pkt_ins  [TOTAL_PKTS];

    int                    pend [NQ][$];
    int                    cur_id    [NQ];
    int                    word_idx  [NQ];
    int                    accepted  [NQ];
    int                    done_cnt  [NQ];
    int                    last_done [NQ];

    pifo_sched_pkg::port_mask_t ready_force;
    logic                       ready_random;
    int                         cyc = 0;
    int                         n_sent;
    int                         errors;
    int                         err_mark;
    int                         tests_run;
    int                         tests_failed;

    tb_clock_gen u_clock_gen
    (
        .axis_aclk   (axis_aclk),
        .axis_resetn (axis_resetn)
    );

    scheduler_top DUT
    (
        .axis_aclk     (axis_aclk),
        .axis_resetn   (axis_resetn),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tkeep  (s_axis_tkeep),
        .s_axis_tuser  (s_axis_tuser),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tready (s_axis_tready),
        .m_axis_tready (m_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tpifo  (m_axis_tpifo),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast)
    );

    always @(posedge axis_aclk)
        cyc <= cyc + 1;

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_data(input pifo_sched_pkg::data_t got,
                              input pifo_sched_pkg::data_t exp, input string what);
        if (got !== exp)
        begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_keep(input pifo_sched_pkg::keep_t got,
                              input pifo_sched_pkg::keep_t exp, input string what);
        if (got !== exp)
        begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_meta(input pifo_sched_pkg::meta_t got,
                              input pifo_sched_pkg::meta_t exp, input string what);
        if (got !== exp)
        begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_rank(input pifo_sched_pkg::rank_t got,
                              input pifo_sched_pkg::rank_t exp, input string what);
        if (got !== exp)
        begin
            $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("FAIL at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // output monitor and ready driver
    ////////////////////////////////////////////////////////////////////////////
    // a beat seen valid here with ready set transfers on the next rising edge
    task automatic watch_port(input int q);
        logic rdy;
        int   pick;
        int   id;
        int   w;
        rdy = ready_random ? 1'($urandom) : ready_force[q];
        m_axis_tready[q] = rdy;
        if (m_axis_tvalid[q] === 1'b1)
        begin
            if (cur_id[q] == -1)
            begin
                // head was popped two edges back, so only older inserts qualify
                pick = -1;
                for (int i = 0; i < pend[q].size(); i++)
                begin
                    id = pend[q][i];
                    if (pkt_ins[id] <= cyc - 2 &&
                        (pick < 0 || pkt_rank[id] < pkt_rank[pend[q][pick]]))
                        pick = i;
                end
                if (pick < 0)
                begin
                    $display("port %0d started a packet at %0t ns that no model entry explains",
                             q, $time);
                    errors++;
                    cur_id[q] = -2;
                end
                else
                begin
                    cur_id[q] = pend[q][pick];
                    pend[q].delete(pick);
                end
                word_idx[q] = 0;
            end
            if (rdy)
            begin
                id = cur_id[q];
                w  = word_idx[q];
                if (id >= 0)
                begin
                    check_data(m_axis_tdata[q], pkt_data[id][w], $sformatf("port %0d tdata", q));
                    check_keep(m_axis_tkeep[q], pkt_keep[id][w], $sformatf("port %0d tkeep", q));
                    check_flag(m_axis_tlast[q], w == pkt_len[id] - 1,
                               $sformatf("port %0d tlast", q));
                    check_meta(m_axis_tuser[q], pkt_meta[id], $sformatf("port %0d tuser", q));
                    check_rank(m_axis_tpifo[q], pkt_rank[id], $sformatf("port %0d tpifo", q));
                end
                if (m_axis_tlast[q])
                begin
                    done_cnt[q]++;
                    last_done[q] = cyc + 1;
                    cur_id[q]    = -1;
                end
                else if (w < `PS_SLOT_WORDS - 1)
                    word_idx[q]++;
            end
        end
    endtask

    // falling edge, then every port is sampled and its ready driven
    task automatic next_cycle();
        @(negedge axis_aclk);
        for (int q = 0; q < NQ; q++)
            watch_port(q);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////
    // queue choice is made one edge after the first beat is sampled
    task automatic accept_pkt(input int id, input logic pvalid);
        int occ;
        for (int q = 0; q < NQ; q++)
        begin
            occ = accepted[q] - done_cnt[q] + ((last_done[q] == cyc + 1) ? 1 : 0);
            if (pvalid && pkt_meta[id].dst_ports[q] && occ < `PS_NUM_SLOTS)
            begin
                accepted[q]++;
                pend[q].push_back(id);
            end
        end
    endtask

    task automatic send_pkt(input pifo_sched_pkg::meta_t meta, input pifo_sched_pkg::rank_t rank,
                            input logic pvalid, input int len);
        pifo_sched_pkg::tuser_in_t tu;
        int                        id;
        id = n_sent;
        n_sent++;
        pkt_len[id]  = len;
        pkt_meta[id] = meta;
        pkt_rank[id] = rank;
        pkt_ins[id]  = 32'h7fff_ffff;
        for (int w = 0; w < len; w++)
        begin
            pkt_data[id][w] = pifo_sched_pkg::data_t'({$urandom, $urandom});
            pkt_keep[id][w] = pifo_sched_pkg::keep_t'($urandom);
        end
        tu.pifo.valid = pvalid;
        tu.pifo.rank  = rank;
        tu.meta       = meta;
        // beats, then four idle cycles
        for (int n = 0; n < len + 4; n++)
        begin
            next_cycle();
            if (n == 1)
                accept_pkt(id, pvalid);
            if (n < len)
            begin
                s_axis_tdata  = pkt_data[id][n];
                s_axis_tkeep  = pkt_keep[id][n];
                s_axis_tuser  = tu;
                s_axis_tvalid = 1'b1;
                s_axis_tlast  = (n == len - 1);
                if (n == len - 1)
                    pkt_ins[id] = cyc + 2;
            end
            else
            begin
                s_axis_tvalid = 1'b0;
                s_axis_tlast  = 1'b0;
            end
        end
    endtask

    task automatic send_random(input pifo_sched_pkg::port_mask_t dst, input int rank_span,
                               input logic pvalid);
        pifo_sched_pkg::meta_t meta;
        meta           = pifo_sched_pkg::meta_t'($urandom);
        meta.dst_ports = dst;
        send_pkt(meta, pifo_sched_pkg::rank_t'($urandom % rank_span), pvalid, 1 + $urandom % 8);
    endtask

    function automatic bit drained();
        for (int q = 0; q < NQ; q++)
            if (pend[q].size() != 0 || cur_id[q] != -1)
                return 1'b0;
        return 1'b1;
    endfunction

    task automatic drain_all();
        while (!drained())
            next_cycle();
        // room for any stray packet to show up
        repeat (20) next_cycle();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == err_mark)
            $display("test %0d %s: passed", tests_run, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end
        err_mark = errors;
    endtask

    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, packets were lost or the run stalled", TIMEOUT_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        void'($urandom(32'h4295faad));
        s_axis_tdata  = '0;
        s_axis_tkeep  = '0;
        s_axis_tuser  = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        m_axis_tready = '1;
        ready_force   = '1;
        ready_random  = 1'b0;
        n_sent        = 0;
        errors        = 0;
        err_mark      = 0;
        tests_run     = 0;
        tests_failed  = 0;
        for (int q = 0; q < NQ; q++)
        begin
            cur_id[q]    = -1;
            word_idx[q]  = 0;
            accepted[q]  = 0;
            done_cnt[q]  = 0;
            last_done[q] = -10;
        end

        @(negedge axis_aclk);
        check_flag(s_axis_tready, 1'b0, "s_axis_tready in reset");
        wait (axis_resetn);
        repeat (2) next_cycle();
        check_flag(s_axis_tready, 1'b1, "s_axis_tready after reset");
        for (int q = 0; q < NQ; q++)
            check_flag(m_axis_tvalid[q], 1'b0, $sformatf("port %0d tvalid after reset", q));
        end_test("reset state");

        send_random(4'b1011, 1 << `PS_RANK_WIDTH, 1'b1);
        drain_all();
        end_test("multicast packet");

        // port 0 stalled and a narrow rank range for ties
        ready_force = 4'b1110;
        for (int i = 0; i < 8; i++)
            send_random(4'b0001, 4, 1'b1);
        ready_force = 4'b1111;
        drain_all();
        end_test("rank order with ties");

        ready_force = 4'b1110;
        for (int i = 0; i < 8; i++)
            send_random(4'b0001, 1 << `PS_RANK_WIDTH, 1'b1);
        send_random(4'b0011, 1 << `PS_RANK_WIDTH, 1'b1);
        ready_force = 4'b1111;
        drain_all();
        end_test("drop on full queue");

        send_random(4'b1111, 1 << `PS_RANK_WIDTH, 1'b0);
        drain_all();
        end_test("pifo valid clear");

        ready_random = 1'b1;
        for (int i = 0; i < N_RAND; i++)
            send_random(pifo_sched_pkg::port_mask_t'(1 + $urandom % 15),
                        1 << `PS_RANK_WIDTH, ($urandom % 8) != 0);
        ready_random = 1'b0;
        drain_all();
        end_test("random traffic");

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
